//--- pwmPkg.sv
// Shared types and constants for the PWM subsystem
// Command and hub state enums, bus fields, block map, CSR offsets
package pwmPkg;

	// ----------------------------------------
	// Types
	// ----------------------------------------

	// Command field of the bus address word
	typedef enum logic [1:0]
	{
		cmdNone      = 2'd0,	// No operation
		cmdWrite     = 2'd1,
		cmdRead      = 2'd2,
		cmdWriteRead = 2'd3	// Decoded but not serviced
	} usiCmd_t;

	// Hub sequencing
	typedef enum logic
	{
		hubIdle   = 1'b0,
		hubWaitRd = 1'b1	// Read issued, waiting on a slave
	} hubState_t;

	// ----------------------------------------
	// Bus layout
	// ----------------------------------------
	localparam int lpDataWidth = 32;
	localparam int lpAdrsWidth = 32;

	localparam int lpCmdHi = 31;	// Command type
	localparam int lpCmdLo = 30;
	localparam int lpBlkHi = 23;	// Block address
	localparam int lpBlkLo = 16;
	localparam int lpCsrHi = 15;	// Register address, down to bit 0

	// PWM counter and duty width
	localparam int lpPwmWidth = 8;

	// Block map
	localparam logic [lpBlkHi-lpBlkLo:0] lpBlkPwm0 = 8'h02;
	localparam logic [lpBlkHi-lpBlkLo:0] lpBlkPwm1 = 8'h03;

	// CSR offsets inside a PWM block
	localparam logic [lpCsrHi:0] lpCsrCtrl = 16'h0000;	// Bit 0 enable
	localparam logic [lpCsrHi:0] lpCsrDuty = 16'h0004;	// 8-bit duty

	// Read return window of the hub, in cycles
	localparam int unsigned lpRdTimeout = 8;
	localparam int lpRdToWidth = $clog2(lpRdTimeout);

endpackage

//--- usiBusIf.sv
// Single-slave bus bundle with master and slave views
interface usiBusIf;

	// Master to slave
	logic [pwmPkg::lpDataWidth-1:0] wd;	// Write data
	logic [pwmPkg::lpAdrsWidth-1:0] adrs;	// Cmd / block / CSR address word
	logic                           wCke;	// One-cycle command strobe

	// Slave to master
	logic [pwmPkg::lpDataWidth-1:0] rd;	// Zero unless answering
	logic                           vd;	// One-cycle read valid

	// Hub side
	modport master
	(
		output wd,
		output adrs,
		output wCke,
		input  rd,
		input  vd
	);

	// Register file side
	modport slave
	(
		input  wd,
		input  adrs,
		input  wCke,
		output rd,
		output vd
	);

endinterface

//--- usiBusHub.sv
// Bus hub: host command register, read data merge, read timeout
module usiBusHub
(
	input  logic                           iSysClk,
	input  logic                           rstN,
	input  logic [pwmPkg::lpDataWidth-1:0] hostWd,
	input  logic [pwmPkg::lpAdrsWidth-1:0] hostAdrs,
	input  logic                           hostWCke,
	output logic [pwmPkg::lpDataWidth-1:0] hostRd,
	output logic                           hostRdVld,
	output logic                           hostRdErr,
	output logic                           hostBusy,
	usiBusIf.master                        bus0,
	usiBusIf.master                        bus1
);

	pwmPkg::hubState_t              state;
	logic [pwmPkg::lpDataWidth-1:0] busWd;		// Registered command payload
	logic [pwmPkg::lpAdrsWidth-1:0] busAdrs;
	logic                           busWCke;
	logic                           hostAccept;
	logic                           hostIsRead;
	logic [pwmPkg::lpDataWidth-1:0] rdAny;		// OR of slave returns
	logic                           vdAny;
	logic [pwmPkg::lpRdToWidth-1:0] rdToCnt;	// Cycles spent in hubWaitRd
	logic                           rdToHit;

	// ----------------------------------------
	// Host side decode
	// ----------------------------------------
	assign hostAccept = hostWCke && (state == pwmPkg::hubIdle);	// Dropped while busy
	assign hostIsRead = (pwmPkg::usiCmd_t'(hostAdrs[pwmPkg::lpCmdHi:pwmPkg::lpCmdLo])
		== pwmPkg::cmdRead);
	assign hostBusy   = (state == pwmPkg::hubWaitRd);

	// ----------------------------------------
	// Command register, broadcast to slaves
	// ----------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (hostAccept)
		begin
			busWd   <= hostWd;
			busAdrs <= hostAdrs;
		end
	end

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			busWCke <= 1'b0;
		else
			busWCke <= hostAccept;	// Strobe one cycle after host
	end

	assign bus0.wd   = busWd;
	assign bus0.adrs = busAdrs;
	assign bus0.wCke = busWCke;
	assign bus1.wd   = busWd;
	assign bus1.adrs = busAdrs;
	assign bus1.wCke = busWCke;

	// ----------------------------------------
	// Read return and timeout
	// ----------------------------------------
	assign rdAny   = bus0.rd | bus1.rd;	// Idle slaves drive zero
	assign vdAny   = bus0.vd | bus1.vd;
	assign rdToHit = (32'(rdToCnt) == pwmPkg::lpRdTimeout - 1);

	// Read data to host
	always_ff @(posedge iSysClk)
	begin
		if (vdAny)
			hostRd <= rdAny;
	end

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			state     <= pwmPkg::hubIdle;
			rdToCnt   <= '0;
			hostRdVld <= 1'b0;
			hostRdErr <= 1'b0;
		end
		else
		begin
			hostRdVld <= 1'b0;	// Both flags are single pulses
			hostRdErr <= 1'b0;
			case (state)
				pwmPkg::hubIdle:
				begin
					rdToCnt <= '0;
					if (hostAccept && hostIsRead)
						state <= pwmPkg::hubWaitRd;
				end
				pwmPkg::hubWaitRd:
				begin
					rdToCnt <= rdToCnt + 1'b1;
					if (vdAny)	// Return wins over a same-cycle timeout
					begin
						hostRdVld <= 1'b1;
						state     <= pwmPkg::hubIdle;
					end
					else if (rdToHit)
					begin
						hostRdErr <= 1'b1;	// Nobody answered
						state     <= pwmPkg::hubIdle;
					end
				end
				default:
					state <= pwmPkg::hubIdle;
			endcase
		end
	end

endmodule

//--- pwmCsr.sv
// PWM register file: enable and duty registers on the slave bus
module pwmCsr
#(
	parameter logic [pwmPkg::lpBlkHi-pwmPkg::lpBlkLo:0] pBlkAdrs = pwmPkg::lpBlkPwm0
)
(
	input  logic                          iSysClk,
	input  logic                          rstN,
	usiBusIf.slave                        bus,
	output logic                          pwmEn,	// Counter run enable
	output logic [pwmPkg::lpPwmWidth-1:0] pwmDuty	// Compare threshold
);

	pwmPkg::usiCmd_t                cmd;
	logic                           blkHit;
	logic [pwmPkg::lpCsrHi:0]       csrAdrs;
	logic                           wrEn;
	logic                           rdEn;
	logic [pwmPkg::lpDataWidth-1:0] rdMux;

	// ----------------------------------------
	// Address word decode
	// ----------------------------------------
	assign cmd     = pwmPkg::usiCmd_t'(bus.adrs[pwmPkg::lpCmdHi:pwmPkg::lpCmdLo]);
	assign blkHit  = (bus.adrs[pwmPkg::lpBlkHi:pwmPkg::lpBlkLo] == pBlkAdrs);
	assign csrAdrs = bus.adrs[pwmPkg::lpCsrHi:0];

	// Only plain write and read are serviced
	assign wrEn = bus.wCke && blkHit && (cmd == pwmPkg::cmdWrite);
	assign rdEn = bus.wCke && blkHit && (cmd == pwmPkg::cmdRead);

	// ----------------------------------------
	// Register writes
	// ----------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			pwmEn   <= 1'b0;
			pwmDuty <= '0;
		end
		else if (wrEn)
		begin
			case (csrAdrs)
				pwmPkg::lpCsrCtrl:
					pwmEn <= bus.wd[0];	// Enable only in bit 0
				pwmPkg::lpCsrDuty:
					pwmDuty <= bus.wd[pwmPkg::lpPwmWidth-1:0];
				default:
					;	// Unmapped offset
			endcase
		end
	end

	// ----------------------------------------
	// Read path
	// ----------------------------------------

	// Zero-extended register select
	always_comb
	begin
		case (csrAdrs)
			pwmPkg::lpCsrCtrl:
				rdMux = {{(pwmPkg::lpDataWidth-1){1'b0}}, pwmEn};
			pwmPkg::lpCsrDuty:
				rdMux = {{(pwmPkg::lpDataWidth-pwmPkg::lpPwmWidth){1'b0}}, pwmDuty};
			default:
				rdMux = '0;	// Unknown offsets read zero
		endcase
	end

	// Return one cycle after the strobe
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			bus.rd <= '0;
			bus.vd <= 1'b0;
		end
		else
		begin
			bus.vd <= rdEn;
			if (rdEn)
				bus.rd <= rdMux;
			else
				bus.rd <= '0;	// Keep hub OR merge clean
		end
	end

endmodule

//--- pwmBlock.sv
// One PWM channel: free-running counter, duty compare, CSR instance
module pwmBlock
#(
	parameter logic [pwmPkg::lpBlkHi-pwmPkg::lpBlkLo:0] pBlkAdrs = pwmPkg::lpBlkPwm0
)
(
	input  logic   iSysClk,
	input  logic   rstN,
	usiBusIf.slave bus,
	output logic   pwm	// Registered compare result
);

	logic                          pwmEn;
	logic [pwmPkg::lpPwmWidth-1:0] pwmDuty;
	logic [pwmPkg::lpPwmWidth-1:0] cnt;	// Wraps at 256
	logic                          cntAbove;

	// ----------------------------------------
	// Counter
	// ----------------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			cnt <= '0;
		else if (pwmEn)
			cnt <= cnt + 1'b1;	// Runs while enabled
		else
			cnt <= '0;	// Held clear when disabled
	end

	// ----------------------------------------
	// Output compare
	// ----------------------------------------

	// High for counter values above duty
	// Gives 255 - duty high cycles per period
	assign cntAbove = (pwmDuty < cnt);

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
			pwm <= 1'b0;
		else
			pwm <= cntAbove;	// One cycle behind the counter
	end

	// ----------------------------------------
	// Register file
	// ----------------------------------------
	pwmCsr
	#(
		.pBlkAdrs	(pBlkAdrs)
	)
	pwmCsrInst
	(
		.iSysClk	(iSysClk),
		.rstN		(rstN),
		.bus		(bus),
		.pwmEn		(pwmEn),
		.pwmDuty	(pwmDuty)
	);

endmodule

//--- pwmSystem.sv
// PWM subsystem top: bus hub, two PWM blocks, one bus bundle each
module pwmSystem
(
	input  logic                           iSysClk,
	input  logic                           rstN,
	// Host command port
	input  logic [pwmPkg::lpDataWidth-1:0] hostWd,
	input  logic [pwmPkg::lpAdrsWidth-1:0] hostAdrs,
	input  logic                           hostWCke,
	output logic [pwmPkg::lpDataWidth-1:0] hostRd,
	output logic                           hostRdVld,
	output logic                           hostRdErr,
	output logic                           hostBusy,
	// PWM pins
	output logic                           pwm0,
	output logic                           pwm1
);

	// One bundle per slave
	usiBusIf bus0If();
	usiBusIf bus1If();

	// ----------------------------------------
	// Bus master
	// ----------------------------------------
	usiBusHub usiBusHubInst
	(
		.iSysClk	(iSysClk),
		.rstN		(rstN),
		.hostWd		(hostWd),
		.hostAdrs	(hostAdrs),
		.hostWCke	(hostWCke),
		.hostRd		(hostRd),
		.hostRdVld	(hostRdVld),
		.hostRdErr	(hostRdErr),
		.hostBusy	(hostBusy),
		.bus0		(bus0If),
		.bus1		(bus1If)
	);

	// ----------------------------------------
	// PWM slaves
	// ----------------------------------------
	pwmBlock #(.pBlkAdrs(pwmPkg::lpBlkPwm0)) pwmBlk0
	(
		.iSysClk	(iSysClk),
		.rstN		(rstN),
		.bus		(bus0If),
		.pwm		(pwm0)
	);

	pwmBlock #(.pBlkAdrs(pwmPkg::lpBlkPwm1)) pwmBlk1
	(
		.iSysClk	(iSysClk),
		.rstN		(rstN),
		.bus		(bus1If),
		.pwm		(pwm1)
	);

endmodule

//--- tb.sv
// Testbench for the PWM subsystem
// Clock, reset, host bus driver, compare tasks and directed tests
module tb;

	logic                           iSysClk;
	logic                           rstN;
	logic [pwmPkg::lpDataWidth-1:0] hostWd;
	logic [pwmPkg::lpAdrsWidth-1:0] hostAdrs;
	logic                           hostWCke;
	logic [pwmPkg::lpDataWidth-1:0] hostRd;
	logic                           hostRdVld;
	logic                           hostRdErr;
	logic                           hostBusy;
	logic                           pwm0;
	logic                           pwm1;
	int                             errCnt;	// Failed compares
	int                             toCnt;	// Expired waits

	pwmSystem UUT
	(
		.iSysClk	(iSysClk),
		.rstN		(rstN),
		.hostWd		(hostWd),
		.hostAdrs	(hostAdrs),
		.hostWCke	(hostWCke),
		.hostRd		(hostRd),
		.hostRdVld	(hostRdVld),
		.hostRdErr	(hostRdErr),
		.hostBusy	(hostBusy),
		.pwm0		(pwm0),
		.pwm1		(pwm1)
	);

	// 10-unit clock
	initial
	begin
		iSysClk = 1'b0;
		forever #5 iSysClk = ~iSysClk;
	end

	// ----------------------------------------
	// Reporting and compares
	// ----------------------------------------
	task automatic finishRun();
		$display("Summary: %0d check errors, %0d timeouts", errCnt, toCnt);
		if (errCnt == 0 && toCnt == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	task automatic timeoutAbort(string what);
		toCnt++;
		$display("Timeout at %0t: no %s from the DUT", $time, what);
		finishRun();
	endtask

	task automatic checkData(string msg, logic [pwmPkg::lpDataWidth-1:0] got,
		logic [pwmPkg::lpDataWidth-1:0] exp);
		if (got !== exp)
		begin
			errCnt++;
			$display("Error %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic checkBit(string msg, logic got, logic exp);
		if (got !== exp)
		begin
			errCnt++;
			$display("Error %0t: %s got %b expected %b", $time, msg, got, exp);
		end
	endtask

	// ----------------------------------------
	// Host driver
	// ----------------------------------------
	function automatic logic [7:0] blkOf(int sel);
		return (sel == 0) ? pwmPkg::lpBlkPwm0 : pwmPkg::lpBlkPwm1;
	endfunction

	function automatic logic pwmPin(int sel);
		return (sel == 0) ? pwm0 : pwm1;
	endfunction

	task automatic waitCycles(int n);
		repeat (n) @(posedge iSysClk);
		#1;	// Back on the drive point
	endtask

	// Ends 1 unit after an edge with the hub idle
	task automatic waitIdle();
		int waitCnt;
		waitCnt = 0;
		@(posedge iSysClk);
		#1;
		while (hostBusy && waitCnt < 100)
		begin
			@(posedge iSysClk);
			#1;
			waitCnt++;
		end
		if (hostBusy)
			timeoutAbort("idle hub, hostBusy stayed high");
	endtask

	// One-cycle host strobe with a built command word
	task automatic sendCmd(pwmPkg::usiCmd_t cmd, logic [7:0] blk, logic [15:0] csr,
		logic [pwmPkg::lpDataWidth-1:0] data);
		logic [pwmPkg::lpAdrsWidth-1:0] adrs;
		adrs = '0;
		adrs[pwmPkg::lpCmdHi:pwmPkg::lpCmdLo] = cmd;
		adrs[pwmPkg::lpBlkHi:pwmPkg::lpBlkLo] = blk;
		adrs[pwmPkg::lpCsrHi:0]               = csr;
		waitIdle();
		hostAdrs = adrs;
		hostWd   = data;
		hostWCke = 1'b1;
		@(posedge iSysClk);
		#1;
		hostWCke = 1'b0;
	endtask

	task automatic busWrite(logic [7:0] blk, logic [15:0] csr,
		logic [pwmPkg::lpDataWidth-1:0] data);
		sendCmd(pwmPkg::cmdWrite, blk, csr, data);
	endtask

	// Waits for the read return or the hub error pulse
	task automatic busRead(logic [7:0] blk, logic [15:0] csr,
		output logic [pwmPkg::lpDataWidth-1:0] data, output logic vld, output logic err);
		int waitCnt;
		waitCnt = 0;
		vld     = 1'b0;
		err     = 1'b0;
		sendCmd(pwmPkg::cmdRead, blk, csr, '0);
		checkBit("hostBusy after read strobe", hostBusy, 1'b1);
		while (!vld && !err && waitCnt < 40)
		begin
			@(posedge iSysClk);
			#1;
			vld  = hostRdVld;
			err  = hostRdErr;
			data = hostRd;
			if (!vld && !err)
				checkBit("hostBusy while read pending", hostBusy, 1'b1);
			waitCnt++;
		end
		if (!vld && !err)
			timeoutAbort("read return or read error");
	endtask

	task automatic readCheck(string msg, logic [7:0] blk, logic [15:0] csr,
		logic [pwmPkg::lpDataWidth-1:0] exp);
		logic [pwmPkg::lpDataWidth-1:0] data;
		logic                           vld;
		logic                           err;
		busRead(blk, csr, data, vld, err);
		checkBit({msg, " valid"}, vld, 1'b1);
		checkBit({msg, " error"}, err, 1'b0);
		checkData(msg, data, exp);
	endtask

	// High cycles of one pin over a window
	task automatic countHigh(int sel, int cycles, output int high);
		high = 0;
		repeat (cycles)
		begin
			@(posedge iSysClk);
			#1;
			if (pwmPin(sel))
				high++;
		end
	endtask

	// Set duty, let it settle, expect 255 - d highs per 256
	task automatic dutyCheck(int sel, logic [7:0] d);
		int high;
		busWrite(blkOf(sel), pwmPkg::lpCsrDuty, 32'(d));
		waitCycles(4);
		countHigh(sel, 256, high);
		checkData($sformatf("pwm%0d high cycles, duty %0d", sel, d), 32'(high), 32'(255 - d));
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic testReset();
		checkBit("hostBusy after reset", hostBusy, 1'b0);
		checkBit("hostRdVld after reset", hostRdVld, 1'b0);
		checkBit("hostRdErr after reset", hostRdErr, 1'b0);
		checkBit("pwm0 after reset", pwm0, 1'b0);
		checkBit("pwm1 after reset", pwm1, 1'b0);
		for (int sel = 0; sel < 2; sel++)
		begin
			readCheck($sformatf("blk%0d ctrl reset", sel), blkOf(sel), pwmPkg::lpCsrCtrl, '0);
			readCheck($sformatf("blk%0d duty reset", sel), blkOf(sel), pwmPkg::lpCsrDuty, '0);
		end
	endtask

	task automatic testRegAccess();
		logic [7:0] d0;
		logic [7:0] d1;
		d0 = 8'($urandom);
		d1 = d0 ^ (8'($urandom % 255) + 8'd1);	// Never equal to d0
		busWrite(pwmPkg::lpBlkPwm0, pwmPkg::lpCsrDuty, 32'(d0));
		busWrite(pwmPkg::lpBlkPwm1, pwmPkg::lpCsrDuty, 32'(d1));
		readCheck("blk0 duty", pwmPkg::lpBlkPwm0, pwmPkg::lpCsrDuty, 32'(d0));
		readCheck("blk1 duty", pwmPkg::lpBlkPwm1, pwmPkg::lpCsrDuty, 32'(d1));
		// Random upper bits with enable set on blk0 and clear on blk1
		busWrite(pwmPkg::lpBlkPwm0, pwmPkg::lpCsrCtrl, $urandom | 32'h1);
		busWrite(pwmPkg::lpBlkPwm1, pwmPkg::lpCsrCtrl, $urandom & ~32'h1);
		readCheck("blk0 ctrl", pwmPkg::lpBlkPwm0, pwmPkg::lpCsrCtrl, 32'h1);
		readCheck("blk1 ctrl", pwmPkg::lpBlkPwm1, pwmPkg::lpCsrCtrl, 32'h0);
		busWrite(pwmPkg::lpBlkPwm0, pwmPkg::lpCsrCtrl, 32'h0);
		readCheck("blk0 unknown offset", pwmPkg::lpBlkPwm0, 16'h0008, '0);
	endtask

	task automatic testDutyRatio();
		for (int sel = 0; sel < 2; sel++)
		begin
			busWrite(blkOf(sel), pwmPkg::lpCsrCtrl, 32'h1);
			repeat (3)
				dutyCheck(sel, 8'($urandom % 255));
			dutyCheck(sel, 8'd255);	// Never above the counter
			busWrite(blkOf(sel), pwmPkg::lpCsrCtrl, 32'h0);
		end
	endtask

	task automatic testDisable();
		int high;
		busWrite(pwmPkg::lpBlkPwm0, pwmPkg::lpCsrCtrl, 32'h1);
		dutyCheck(0, 8'($urandom % 255));
		busWrite(pwmPkg::lpBlkPwm0, pwmPkg::lpCsrCtrl, 32'h0);
		waitCycles(3);	// Enable clear, counter clear, pin
		countHigh(0, 300, high);
		checkData("pwm0 high cycles while disabled", 32'(high), 32'h0);
		busWrite(pwmPkg::lpBlkPwm0, pwmPkg::lpCsrCtrl, 32'h1);
		dutyCheck(0, 8'($urandom % 255));
		busWrite(pwmPkg::lpBlkPwm0, pwmPkg::lpCsrCtrl, 32'h0);
	endtask

	task automatic testNoAnswer();
		logic [pwmPkg::lpDataWidth-1:0] data;
		logic                           vld;
		logic                           err;
		busRead(8'h7F, pwmPkg::lpCsrCtrl, data, vld, err);
		checkBit("unanswered read error", err, 1'b1);
		checkBit("unanswered read valid", vld, 1'b0);
		checkBit("hostBusy at read error", hostBusy, 1'b0);
		waitCycles(1);
		checkBit("hostBusy after read error", hostBusy, 1'b0);
		checkBit("hostRdVld after read error", hostRdVld, 1'b0);
	endtask

	task automatic testIgnoredCmd();
		logic [7:0] v;
		v = 8'($urandom);
		busWrite(pwmPkg::lpBlkPwm1, pwmPkg::lpCsrDuty, 32'(v));
		sendCmd(pwmPkg::cmdWriteRead, pwmPkg::lpBlkPwm1, pwmPkg::lpCsrDuty, 32'(~v));
		waitCycles(3);
		readCheck("blk1 duty after write-read", pwmPkg::lpBlkPwm1, pwmPkg::lpCsrDuty, 32'(v));
	endtask

	// ----------------------------------------
	// Main sequence
	// ----------------------------------------
	initial
	begin
		errCnt   = 0;
		toCnt    = 0;
		rstN     = 1'b0;
		hostWd   = '0;
		hostAdrs = '0;
		hostWCke = 1'b0;
		void'($urandom(58));	// Fixed seed
		repeat (4) @(posedge iSysClk);
		#1;
		rstN = 1'b1;
		waitCycles(1);
		testReset();
		testRegAccess();
		testDutyRatio();
		testDisable();
		testNoAnswer();
		testIgnoredCmd();
		finishRun();
	end

endmodule

//--- tb.f
pwmPkg.sv
usiBusIf.sv
usiBusHub.sv
pwmCsr.sv
pwmBlock.sv
pwmSystem.sv
tb.sv

//--- run.sh
#!/bin/sh
# Compile the PWM subsystem testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module tb -o tbSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

if [ ! -x ./obj_dir/tbSim ]; then
	echo "Simulation executable not found"
	exit 1
fi

output=$(./obj_dir/tbSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qxF '*** PASSED ***'; then
	exit 0
fi

echo "Pass message not found in simulation output"
exit 1
